/* bench/icmp_responder_assertions.sv */
/*
  protocol checks bound into the echo responder top level
  the FIFO and receiver state are taken from inside the design
*/
module icmp_responder_assertions (
  input logic                rx_clock,
  input logic                rst_n,
  input logic                tx_request,
  input logic                tx_active,
  input logic                dst_unreachable,
  input logic                fifo_write,
  input logic                fifo_empty,
  input logic [15:0]         length,
  input icmp_pkg::rx_state_t rx_state
);

  import icmp_pkg::*;

  // --------------------------------------------------
  // host handshake
  // --------------------------------------------------
  request_or_active: assert property (@(posedge rx_clock) disable iff (!rst_n)
    !(tx_request && tx_active))
    else $error("tx_request and tx_active are high together");

  // flag is a single-cycle pulse
  unreachable_pulse: assert property (@(posedge rx_clock) disable iff (!rst_n)
    dst_unreachable |=> !dst_unreachable)
    else $error("dst_unreachable held longer than one cycle");

  // payload writes stop once the received count reaches the FIFO capacity
  write_below_capacity: assert property (@(posedge rx_clock) disable iff (!rst_n)
    fifo_write |-> (length < header_len + 16'(fifo_depth)))
    else $error("payload FIFO written beyond its capacity");

  // reply only runs while the receiver waits in its tx state
  active_in_tx_state: assert property (@(posedge rx_clock) disable iff (!rst_n)
    tx_active |-> (rx_state == rx_tx))
    else $error("tx_active outside the receiver tx state");

  // a reply ends only after the whole header and once the payload is drained
  active_until_drained: assert property (@(posedge rx_clock) disable iff (!rst_n)
    $fell(tx_active) |-> (fifo_empty && $past(tx_active, header_len)))
    else $error("tx_active dropped before the reply was complete");

endmodule

bind icmp_responder icmp_responder_assertions u_assertions (
  .rx_clock        (rx_clock),
  .rst_n           (rst_n),
  .tx_request      (tx_request),
  .tx_active       (tx_active),
  .dst_unreachable (dst_unreachable),
  .fifo_write      (fifo_bus.write),
  .fifo_empty      (fifo_bus.empty),
  .length          (length),
  .rx_state        (u_receiver.state)
);

/* bench/icmp_responder_tb.sv */
/*
  testbench for the ICMP echo responder
  random messages from a fixed seed, each reply compared with a byte model
  inputs change and outputs are sampled one time unit after the rising edge
  every wait is bounded, a timeout ends the run early as a failure
*/
module icmp_responder_tb;

  import icmp_pkg::*;

  logic        rst_n;
  logic        rx_clock;
  logic        rx_enable;
  logic [7:0]  rx_data;
  mac_t        remote_mac;
  ip_t         remote_ip;
  logic        tx_enable;
  logic        tx_request;
  logic        tx_active;
  logic [7:0]  tx_data;
  logic [15:0] length;
  mac_t        destination_mac;
  ip_t         destination_ip;
  logic        dst_unreachable;

  integer      seed;
  int          errors;
  int          checks;
  bit          timed_out;
  int          kind;
  // filled by the monitor
  logic [7:0]  tx_bytes[$];
  int          unreach_pulses;
  int          active_runs;
  logic        active_prev;

  icmp_responder u_dut (.*);

  always #5 rx_clock = ~rx_clock;

  // --------------------------------------------------
  // monitor, samples in the middle of the cycle
  // --------------------------------------------------
  always @(negedge rx_clock)
  begin
    if (rst_n)
    begin
      if (tx_active)
        tx_bytes.push_back(tx_data);
      // one run per reply, a gap would count twice
      if (tx_active && !active_prev)
        active_runs++;
      if (dst_unreachable)
        unreach_pulses++;
      active_prev = tx_active;
    end
  end

  function automatic int pick_range(int lo, int hi);
    int unsigned r;
    r = $random(seed);
    return lo + int'(r % (hi - lo + 1));
  endfunction

  // one's-complement sum over 16-bit words, carries folded once
  function automatic logic [15:0] fold_checksum(input logic [7:0] payload[$]);
    logic [31:0] sum;
    logic [15:0] folded;
    sum = 32'd0;
    for (int i = 0; i < payload.size(); i++)
    begin
      // even offsets are the high byte of a word
      if (i % 2 == 0)
        sum = sum + {16'd0, payload[i], 8'd0};
      else
        sum = sum + {24'd0, payload[i]};
    end
    folded = sum[15:0] + sum[31:16];
    return ~folded;
  endfunction

  task automatic tick();
    @(posedge rx_clock);
    #1;
  endtask

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("Mismatch %s: expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(string what);
    errors++;
    timed_out = 1'b1;
    $display("error: no %s within the time limit", what);
  endtask

  task automatic random_addresses();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    remote_mac = {hi[15:0], lo};
    remote_ip  = $random(seed);
  endtask

  // one byte per cycle, rx_enable low again after the last byte
  task automatic send_message(input logic [7:0] bytes[$]);
    for (int i = 0; i < bytes.size(); i++)
    begin
      rx_enable = 1'b1;
      rx_data   = bytes[i];
      tick();
      // destination is latched with the type byte, later changes must not reach it
      if (i == 0)
        random_addresses();
    end
    rx_enable = 1'b0;
    rx_data   = 8'h00;
  endtask

  // --------------------------------------------------
  // echo request, optionally with a second message while pending
  // --------------------------------------------------
  task automatic run_echo(string name, int payload_len, bit overlap);
    logic [7:0]  payload[$];
    logic [7:0]  msg[$];
    logic [7:0]  other[$];
    logic [7:0]  expected[$];
    logic [15:0] cs;
    mac_t        exp_mac;
    ip_t         exp_ip;
    int          cycles;
    int          runs_before;
    int          pulses_before;
    int          extra_len;
    int          grant_delay;
    if (timed_out)
      return;
    random_addresses();
    exp_mac = remote_mac;
    exp_ip  = remote_ip;
    msg = '{type_echo_request, 8'h00, 8'(pick_range(0, 255)), 8'(pick_range(0, 255))};
    for (int i = 0; i < payload_len; i++)
    begin
      payload.push_back(8'(pick_range(0, 255)));
      msg.push_back(payload[i]);
    end
    // reply model
    cs = fold_checksum(payload);
    expected = '{type_echo_reply, 8'h00, cs[15:8], cs[7:0]};
    for (int i = 0; i < payload_len; i++)
      expected.push_back(payload[i]);
    runs_before   = active_runs;
    pulses_before = unreach_pulses;
    send_message(msg);

    cycles = 0;
    while (!tx_request && cycles < 20)
    begin
      tick();
      cycles++;
    end
    if (!tx_request)
    begin
      report_timeout({name, " tx_request"});
      return;
    end
    check_value({name, " request latency"}, 64'd1, 64'(cycles));

    // a second echo while pending is ignored
    if (overlap)
    begin
      other = '{type_echo_request, 8'h00, 8'h12, 8'h34};
      extra_len = pick_range(0, 20);
      for (int i = 0; i < extra_len; i++)
        other.push_back(8'(pick_range(0, 255)));
      send_message(other);
      tick();
      check_value({name, " request held"}, 64'd1, 64'(tx_request));
    end
    check_value({name, " length"}, 64'(int'(header_len) + payload_len), 64'(length));
    check_value({name, " destination_mac"}, 64'(exp_mac), 64'(destination_mac));
    check_value({name, " destination_ip"}, 64'(exp_ip), 64'(destination_ip));

    // host back-pressure, request must wait
    grant_delay = pick_range(0, 6);
    for (int i = 0; i < grant_delay; i++)
    begin
      check_value({name, " request while waiting"}, 64'd1, 64'(tx_request));
      check_value({name, " idle before grant"}, 64'd0, 64'(tx_active));
      tick();
    end
    tx_bytes.delete();
    tx_enable = 1'b1;
    tick();
    tx_enable = 1'b0;
    check_value({name, " request after grant"}, 64'd0, 64'(tx_request));

    cycles = 0;
    while (!tx_active && cycles < 10)
    begin
      tick();
      cycles++;
    end
    if (!tx_active)
    begin
      report_timeout({name, " tx_active"});
      return;
    end
    check_value({name, " start latency"}, 64'd0, 64'(cycles));
    cycles = 0;
    while (tx_active && cycles < 200)
    begin
      cycles++;
      tick();
    end
    if (tx_active)
    begin
      report_timeout({name, " end of reply"});
      return;
    end
    check_value({name, " active cycles"}, 64'(int'(header_len) + payload_len), 64'(cycles));
    check_value({name, " reply runs"}, 64'd1, 64'(active_runs - runs_before));
    check_value({name, " reply size"}, 64'(expected.size()), 64'(tx_bytes.size()));
    for (int i = 0; i < expected.size() && i < tx_bytes.size(); i++)
      check_value({name, " reply byte"}, 64'(expected[i]), 64'(tx_bytes[i]));
    check_value({name, " no flag"}, 64'(pulses_before), 64'(unreach_pulses));
    // receiver returns to idle one cycle after the reply
    tick();
    tick();
  endtask

  // --------------------------------------------------
  // messages that get no reply
  // 1 unreachable, 2 wrong code, 3 other type, 4 cut short, 5 too long
  // --------------------------------------------------
  task automatic run_silent(string name, int kind);
    logic [7:0] msg[$];
    logic [7:0] t;
    int         extra;
    int         pulses_before;
    if (timed_out)
      return;
    pulses_before = unreach_pulses;
    extra = 0;
    case (kind)
      1:
      begin
        msg.push_back(type_dest_unreachable);
        extra = pick_range(0, 6);
      end
      2:
      begin
        msg.push_back(type_echo_request);
        msg.push_back(8'(pick_range(1, 255)));
        extra = pick_range(2, 12);
      end
      3:
      begin
        // any type except 3 and 8
        t = 8'(pick_range(0, 253));
        if (t >= type_dest_unreachable)
          t = t + 8'd1;
        if (t >= type_echo_request)
          t = t + 8'd1;
        msg.push_back(t);
        extra = pick_range(0, 12);
      end
      4:
      begin
        msg.push_back(type_echo_request);
        if (pick_range(0, 1) == 1)
        begin
          msg.push_back(8'h00);
          extra = pick_range(0, 1);
        end
      end
      default:
      begin
        msg.push_back(type_echo_request);
        msg.push_back(8'h00);
        extra = 2 + pick_range(fifo_depth + 1, fifo_depth + 6);
      end
    endcase
    for (int i = 0; i < extra; i++)
      msg.push_back(8'(pick_range(0, 255)));
    send_message(msg);
    for (int i = 0; i < 8; i++)
    begin
      check_value({name, " tx_request"}, 64'd0, 64'(tx_request));
      check_value({name, " tx_active"}, 64'd0, 64'(tx_active));
      tick();
    end
    check_value({name, " flag pulses"}, 64'(kind == 1), 64'(unreach_pulses - pulses_before));
  endtask

  // --------------------------------------------------
  // sequence
  // --------------------------------------------------
  initial
  begin
    seed           = 32'hcaa7;
    errors         = 0;
    checks         = 0;
    timed_out      = 1'b0;
    unreach_pulses = 0;
    active_runs    = 0;
    active_prev    = 1'b0;
    rx_clock       = 1'b0;
    rst_n          = 1'b0;
    rx_enable      = 1'b0;
    rx_data        = 8'h00;
    remote_mac     = '0;
    remote_ip      = '0;
    tx_enable      = 1'b0;
    repeat (10) tick();
    check_value("reset tx_request", 64'd0, 64'(tx_request));
    check_value("reset tx_active", 64'd0, 64'(tx_active));
    check_value("reset dst_unreachable", 64'd0, 64'(dst_unreachable));
    check_value("reset fifo empty", 64'd1, 64'(u_dut.fifo_bus.empty));
    rst_n = 1'b1;
    tick();

    run_echo("echo empty", 0, 1'b0);
    run_echo("echo one", 1, 1'b0);
    run_echo("echo odd", 37, 1'b0);
    run_echo("echo full", fifo_depth, 1'b0);
    run_silent("unreachable", 1);
    run_silent("wrong code", 2);
    run_silent("other type", 3);
    run_silent("cut short", 4);
    run_silent("too long", 5);
    run_echo("echo after too long", 50, 1'b0);
    run_echo("overlap", 20, 1'b1);

    for (int i = 0; i < 60 && !timed_out; i++)
    begin
      kind = pick_range(0, 7);
      if (kind == 0 || kind == 6)
        run_echo("random echo", pick_range(0, fifo_depth), 1'b0);
      else if (kind == 7)
        run_echo("random overlap", pick_range(0, fifo_depth), 1'b1);
      else
      begin
        run_silent("random drop", kind);
        if (kind == 5)
          run_echo("random echo after drop", pick_range(0, fifo_depth), 1'b0);
      end
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* icmp_responder.f */
source/icmp_pkg.sv
source/byte_fifo_if.sv
source/payload_fifo.sv
source/echo_receiver.sv
source/echo_transmitter.sv
source/icmp_responder.sv
bench/icmp_responder_assertions.sv
bench/icmp_responder_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the ICMP echo responder testbench with Verilator and run it
# exit status is 0 only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module icmp_responder_tb -f icmp_responder.f -o icmp_responder_sim &&
  ./obj_dir/icmp_responder_sim | tee /dev/stderr | grep -qx "TESTS PASSED" &&
  echo "run_sim: simulation passed" ||
  { echo "run_sim: simulation failed"; exit 1; }

/* source/byte_fifo_if.sv */
/*
  byte FIFO bus between receiver, payload store and transmitter
  clear wins over write and read, a write while full is dropped
*/
interface byte_fifo_if;

  // write side
  logic       clear;
  logic       write;
  logic [7:0] write_data;
  logic       full;

  // read side, read_data shows the oldest entry
  logic       read;
  logic [7:0] read_data;
  logic       empty;

  modport writer (
    output clear,
    output write,
    output write_data,
    input  full
  );

  modport reader (
    output read,
    input  read_data,
    input  empty
  );

  modport store (
    input  clear,
    input  write,
    input  write_data,
    input  read,
    output full,
    output read_data,
    output empty
  );

endinterface

/* source/echo_receiver.sv */
/*
  ICMP receive side of the echo responder
  expects the message to start with the type byte, rx_enable high for the
  whole message and low for at least one cycle between messages
  incoming checksums are not verified
  anything arriving while a reply is pending or in flight is ignored
*/
module echo_receiver (
  input  logic            rst_n,
  input  logic            rx_clock,
  input  logic            rx_enable,
  input  logic [7:0]      rx_data,
  input  icmp_pkg::mac_t  remote_mac,
  input  icmp_pkg::ip_t   remote_ip,
  input  logic            sending,
  output logic            reply_pending,
  output logic            dst_unreachable,
  output logic [15:0]     checksum,
  output logic [15:0]     length,
  output icmp_pkg::mac_t  destination_mac,
  output icmp_pkg::ip_t   destination_ip,
  byte_fifo_if.writer     fifo
);

  import icmp_pkg::*;

  rx_state_t   state;
  // header bytes left after the type byte
  logic [1:0]  byte_no;
  logic [31:0] sum;
  logic        payload_byte;

  // a payload byte that fits in the FIFO
  assign payload_byte = (state == rx_payload) && rx_enable && !fifo.full;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge rx_clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= rx_idle;
      byte_no <= 2'd0;
    end
    else
    begin
      case (state)
        rx_idle:
        begin
          // first byte of a message is the type
          if (rx_enable)
          begin
            byte_no <= 2'd2;
            if (rx_data == type_echo_request)
              state <= rx_header;
            else if (rx_data == type_dest_unreachable)
              state <= rx_unreachable;
            else
              state <= rx_discard;
          end
        end

        rx_header:
        begin
          // message cut short, nothing to answer
          if (!rx_enable)
            state <= rx_idle;
          // code byte must be zero
          else if ((byte_no == 2'd2) && (rx_data != 8'd0))
            state <= rx_discard;
          // last checksum byte, payload follows
          else if (byte_no == 2'd0)
            state <= rx_payload;
          else
            byte_no <= byte_no - 2'd1;
        end

        rx_payload:
        begin
          if (!rx_enable)
            state <= rx_tx_request;
          // payload too long for the FIFO
          else if (fifo.full)
            state <= rx_discard;
        end

        // wait for the transmitter to take the reply
        rx_tx_request:
        begin
          if (sending)
            state <= rx_tx;
        end

        rx_tx:
        begin
          // skip the tail of a message that started during the reply
          if (!sending)
            state <= rx_enable ? rx_discard : rx_idle;
        end

        rx_discard:
        begin
          if (!rx_enable)
            state <= rx_idle;
        end

        // one cycle only, flag is decoded from the state
        rx_unreachable:
          state <= rx_discard;

        default:
          state <= rx_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // length, checksum sum and reply destination
  // --------------------------------------------------
  always_ff @(posedge rx_clock)
  begin
    if ((state == rx_idle) && rx_enable)
    begin
      sum             <= 32'd0;
      length          <= header_len;
      destination_mac <= remote_mac;
      destination_ip  <= remote_ip;
    end
    else if (payload_byte)
    begin
      // even length puts the byte in the high half of a 16-bit word
      if (length[0])
        sum <= sum + {24'd0, rx_data};
      else
        sum <= sum + {16'd0, rx_data, 8'd0};
      length <= length + 16'd1;
    end
  end

  // fold the carries once and invert
  assign checksum = ~(sum[15:0] + sum[31:16]);

  assign reply_pending   = state == rx_tx_request;
  assign dst_unreachable = state == rx_unreachable;

  // FIFO is emptied between messages
  assign fifo.clear      = state == rx_idle;
  assign fifo.write      = payload_byte;
  assign fifo.write_data = rx_data;

endmodule

/* source/echo_transmitter.sv */
/*
  ICMP echo reply sender
  a grant (tx_enable) is only taken while a reply is pending
  once started the reply runs without pause: four header bytes, then
  one payload byte per cycle until the FIFO is empty
*/
module echo_transmitter (
  input  logic         rst_n,
  input  logic         rx_clock,
  input  logic         tx_enable,
  input  logic         reply_pending,
  input  logic [15:0]  checksum,
  output logic         sending,
  output logic         tx_active,
  output logic [7:0]   tx_data,
  byte_fifo_if.reader  fifo
);

  import icmp_pkg::*;

  logic       busy;
  // header byte index, stops at header_len during the payload
  logic [2:0] hdr_byte;
  logic       start;
  logic       payload_phase;

  assign start         = reply_pending && tx_enable && !busy;
  assign payload_phase = hdr_byte == header_len[2:0];

  // drops in the cycle where the FIFO runs empty
  assign tx_active = busy && !(payload_phase && fifo.empty);
  // seen by the receiver already in the grant cycle
  assign sending   = start || tx_active;

  // pop the byte that is on tx_data now
  assign fifo.read = tx_active && payload_phase;

  // --------------------------------------------------
  // reply sequencing
  // --------------------------------------------------
  always_ff @(posedge rx_clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      hdr_byte <= 3'd0;
    end
    else if (!busy)
    begin
      hdr_byte <= 3'd0;
      if (start)
        busy <= 1'b1;
    end
    else if (!payload_phase)
      hdr_byte <= hdr_byte + 3'd1;
    else if (fifo.empty)
      busy <= 1'b0;
  end

  // header bytes first, then the stored payload
  always_comb
  begin
    case (hdr_byte)
      3'd0:    tx_data = type_echo_reply;
      3'd1:    tx_data = 8'd0;
      3'd2:    tx_data = checksum[15:8];
      3'd3:    tx_data = checksum[7:0];
      default: tx_data = fifo.read_data;
    endcase
  end

endmodule

/* source/icmp_pkg.sv */
/*
  shared constants and types for the ICMP echo responder
  payload capacity is fixed at fifo_depth bytes, longer echoes are dropped
  fifo_addr_w must equal log2(fifo_depth)
*/
package icmp_pkg;

  // --------------------------------------------------
  // ICMP message types, first byte of a message
  // --------------------------------------------------
  localparam logic [7:0] type_echo_reply       = 8'd0;
  localparam logic [7:0] type_dest_unreachable = 8'd3;
  localparam logic [7:0] type_echo_request     = 8'd8;

  // type, code and two checksum bytes ahead of the payload
  localparam logic [15:0] header_len = 16'd4;

  // --------------------------------------------------
  // payload storage
  // --------------------------------------------------
  localparam int fifo_depth  = 64;
  localparam int fifo_addr_w = 6;

  // receiver FSM
  typedef enum logic [2:0] {
    rx_idle,
    rx_header,
    rx_payload,
    rx_tx_request,
    rx_tx,
    rx_discard,
    rx_unreachable
  } rx_state_t;

  // addresses of the remote station
  typedef logic [47:0] mac_t;
  typedef logic [31:0] ip_t;

endpackage

/* source/icmp_responder.sv */
/*
  ICMP echo responder, top level
  single clock domain on rx_clock, asynchronous active-low reset
  tx_request waits for tx_enable, the reply then streams on tx_data
  while tx_active is high
*/
module icmp_responder (
  input  logic            rst_n,
  input  logic            rx_clock,
  input  logic            rx_enable,
  input  logic [7:0]      rx_data,
  input  icmp_pkg::mac_t  remote_mac,
  input  icmp_pkg::ip_t   remote_ip,
  input  logic            tx_enable,
  output logic            tx_request,
  output logic            tx_active,
  output logic [7:0]      tx_data,
  output logic [15:0]     length,
  output icmp_pkg::mac_t  destination_mac,
  output icmp_pkg::ip_t   destination_ip,
  output logic            dst_unreachable
);

  logic        reply_pending;
  logic        sending;
  logic [15:0] checksum;

  // payload path from receiver to transmitter
  byte_fifo_if fifo_bus ();

  payload_fifo u_fifo (
    .rst_n    (rst_n),
    .rx_clock (rx_clock),
    .fifo     (fifo_bus.store)
  );

  echo_receiver u_receiver (
    .rst_n           (rst_n),
    .rx_clock        (rx_clock),
    .rx_enable       (rx_enable),
    .rx_data         (rx_data),
    .remote_mac      (remote_mac),
    .remote_ip       (remote_ip),
    .sending         (sending),
    .reply_pending   (reply_pending),
    .dst_unreachable (dst_unreachable),
    .checksum        (checksum),
    .length          (length),
    .destination_mac (destination_mac),
    .destination_ip  (destination_ip),
    .fifo            (fifo_bus.writer)
  );

  echo_transmitter u_transmitter (
    .rst_n         (rst_n),
    .rx_clock      (rx_clock),
    .tx_enable     (tx_enable),
    .reply_pending (reply_pending),
    .checksum      (checksum),
    .sending       (sending),
    .tx_active     (tx_active),
    .tx_data       (tx_data),
    .fifo          (fifo_bus.reader)
  );

  // request stays up until the transmitter takes the reply
  assign tx_request = reply_pending;

endmodule

/* source/payload_fifo.sv */
/*
  show-ahead byte FIFO, single clock
  read_data is valid whenever empty is low, a read pops at the clock edge
  clear is synchronous and has priority, the memory itself is not reset
*/
module payload_fifo (
  input logic          rst_n,
  input logic          rx_clock,
  byte_fifo_if.store   fifo
);

  import icmp_pkg::*;

  logic [7:0]             mem [fifo_depth];
  logic [fifo_addr_w-1:0] wr_ptr;
  logic [fifo_addr_w-1:0] rd_ptr;
  // one bit wider than the pointers so that full can be told from empty
  logic [fifo_addr_w:0]   count;
  logic                   do_write;
  logic                   do_read;

  // requests that would overflow or underflow are ignored
  assign do_write = fifo.write && !fifo.full && !fifo.clear;
  assign do_read  = fifo.read && !fifo.empty && !fifo.clear;

  assign fifo.full      = count == (fifo_addr_w + 1)'(fifo_depth);
  assign fifo.empty     = count == '0;
  assign fifo.read_data = mem[rd_ptr];

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge rx_clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (fifo.clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_write)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_read)
        rd_ptr <= rd_ptr + 1'b1;
      // count only moves when exactly one side is active
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge rx_clock)
  begin
    if (do_write)
      mem[wr_ptr] <= fifo.write_data;
  end

endmodule
